// File: source/isa_pkg.sv
package isa_pkg;

  // ======================================
  // Major opcodes
  // ======================================
  localparam logic [6:0] OPC_LOAD    = 7'b0000011;
  localparam logic [6:0] OPC_LOAD_FP = 7'b0000111;
  localparam logic [6:0] OPC_OP      = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM  = 7'b0010011;
  localparam logic [6:0] OPC_OP_FP   = 7'b1010011;
  localparam logic [6:0] OPC_FMADD   = 7'b1000011;
  localparam logic [6:0] OPC_STORE   = 7'b0100011;
  localparam logic [6:0] OPC_SYSTEM  = 7'b1110011;

  // MUL, DIV and REM all share this funct7 inside OPC_OP
  localparam logic [6:0] FUNCT7_MULDIV = 7'b0000001;

  // Upper five bits of funct7 that pick the OP-FP operation
  localparam logic [4:0] FP5_SQRT    = 5'b01011;
  localparam logic [4:0] FP5_CMP     = 5'b10100;
  localparam logic [4:0] FP5_CVT_W_S = 5'b11000;
  localparam logic [4:0] FP5_CVT_S_W = 5'b11010;
  localparam logic [4:0] FP5_MV_X_W  = 5'b11100;
  localparam logic [4:0] FP5_MV_W_X  = 5'b11110;

  // FP exception flags, rounding mode, and the combined view of both
  localparam logic [11:0] CSR_FFLAGS = 12'h001;
  localparam logic [11:0] CSR_FRM    = 12'h002;
  localparam logic [11:0] CSR_FCSR   = 12'h003;

  // ======================================
  // Instruction word views
  // ======================================
  // R4-type is a superset of R-type, so funct7 is {rs3, fmt}
  typedef struct packed {
    logic [4:0] rs3;
    logic [1:0] fmt;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } r4_view_t;

  // In the immediate CSR forms the rs1 field carries a 5-bit zero-extended value
  typedef struct packed {
    logic [11:0] csr_addr;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } csr_view_t;

  typedef union packed {
    r4_view_t  r4;
    csr_view_t csr;
  } instr_word_u;

endpackage

// File: source/pipe_pkg.sv
package pipe_pkg;

  // ======================================
  // Micro-op descriptor
  // ======================================
  // Everything the hazard logic needs to know about one instruction.
  // Source fields that the instruction does not read stay zero
  typedef struct packed {
    logic       valid;
    // Integer destination, zero when the result goes to the FP file
    logic [4:0] rd;
    // FP destination, only meaningful together with writes_fp
    logic [4:0] fp_rd;
    logic [4:0] rs1;
    logic [4:0] rs2;
    // FP sources are only filled in for instructions that read the FP file.
    // Slots the instruction does not read repeat fp_rs1 because f0 is a real register
    logic [4:0] fp_rs1;
    logic [4:0] fp_rs2;
    logic [4:0] fp_rs3;
    logic       is_load;
    logic       is_fp_load;
    // Writes the FP register file
    logic       writes_fp;
    // Occupies the M unit for more than one cycle
    logic       is_muldiv;
    logic       is_csr;
    logic       writes_csr;
    // Touches fflags, frm or fcsr
    logic       fp_csr_access;
    logic       uses_fp_src;
  } uop_t;

  localparam uop_t UOP_INVALID = '0;

  // ======================================
  // Per-stage state seen by the hazard unit
  // ======================================
  typedef struct packed {
    uop_t uop;
    // No multi-cycle result is outstanding for the stored uop
    logic completed;
    // The stage keeps its contents across the next edge
    logic holding;
  } slot_state_t;

  // EX, MEM and WB
  localparam int NUM_SLOTS_DEFAULT = 3;

endpackage

// File: source/instr_decoder.sv
module instr_decoder import isa_pkg::*, pipe_pkg::*; (
  input  logic        clk,
  input  instr_word_u instr,
  input  logic        instr_valid,
  input  logic        stall,
  output uop_t        id_uop,
  output uop_t        issue_uop
);

  logic [6:0] funct7;
  logic [4:0] fp_funct5;
  logic       csr_is_fp;

  // funct7 only exists in the R4 view, split across rs3 and fmt
  assign funct7    = {instr.r4.rs3, instr.r4.fmt};
  assign fp_funct5 = instr.r4.rs3;

  assign csr_is_fp = (instr.csr.csr_addr == CSR_FFLAGS) ||
                     (instr.csr.csr_addr == CSR_FRM) ||
                     (instr.csr.csr_addr == CSR_FCSR);

  // ======================================
  // Decode
  // ======================================
  always_comb begin
    id_uop       = UOP_INVALID;
    id_uop.valid = instr_valid;
    case (instr.r4.opcode)
      OPC_LOAD: begin
        id_uop.is_load = 1'b1;
        id_uop.rd      = instr.r4.rd;
        id_uop.rs1     = instr.r4.rs1;
      end
      OPC_LOAD_FP: begin
        // Address comes from the integer file, data goes to the FP file
        id_uop.is_fp_load = 1'b1;
        id_uop.writes_fp  = 1'b1;
        id_uop.fp_rd      = instr.r4.rd;
        id_uop.rs1        = instr.r4.rs1;
      end
      OPC_OP: begin
        id_uop.rd        = instr.r4.rd;
        id_uop.rs1       = instr.r4.rs1;
        id_uop.rs2       = instr.r4.rs2;
        id_uop.is_muldiv = (funct7 == FUNCT7_MULDIV);
      end
      OPC_OP_IMM: begin
        id_uop.rd  = instr.r4.rd;
        id_uop.rs1 = instr.r4.rs1;
      end
      OPC_STORE: begin
        id_uop.rs1 = instr.r4.rs1;
        id_uop.rs2 = instr.r4.rs2;
      end
      OPC_OP_FP: begin
        case (fp_funct5)
          FP5_CVT_S_W, FP5_MV_W_X: begin
            // Integer source moved into the FP file
            id_uop.rs1       = instr.r4.rs1;
            id_uop.writes_fp = 1'b1;
            id_uop.fp_rd     = instr.r4.rd;
          end
          FP5_CMP: begin
            // Compare reads two FP sources and writes an integer result
            id_uop.uses_fp_src = 1'b1;
            id_uop.fp_rs1      = instr.r4.rs1;
            id_uop.fp_rs2      = instr.r4.rs2;
            id_uop.fp_rs3      = instr.r4.rs1;
            id_uop.rd          = instr.r4.rd;
          end
          FP5_CVT_W_S, FP5_MV_X_W: begin
            // The rs2 field is a sub-opcode here and not a register
            id_uop.uses_fp_src = 1'b1;
            id_uop.fp_rs1      = instr.r4.rs1;
            id_uop.fp_rs2      = instr.r4.rs1;
            id_uop.fp_rs3      = instr.r4.rs1;
            id_uop.rd          = instr.r4.rd;
          end
          FP5_SQRT: begin
            id_uop.uses_fp_src = 1'b1;
            id_uop.fp_rs1      = instr.r4.rs1;
            id_uop.fp_rs2      = instr.r4.rs1;
            id_uop.fp_rs3      = instr.r4.rs1;
            id_uop.writes_fp   = 1'b1;
            id_uop.fp_rd       = instr.r4.rd;
          end
          default: begin
            // Two-operand arithmetic, sign injection, min and max
            id_uop.uses_fp_src = 1'b1;
            id_uop.fp_rs1      = instr.r4.rs1;
            id_uop.fp_rs2      = instr.r4.rs2;
            id_uop.fp_rs3      = instr.r4.rs1;
            id_uop.writes_fp   = 1'b1;
            id_uop.fp_rd       = instr.r4.rd;
          end
        endcase
      end
      OPC_FMADD: begin
        // The only format that reads a third FP source
        id_uop.uses_fp_src = 1'b1;
        id_uop.fp_rs1      = instr.r4.rs1;
        id_uop.fp_rs2      = instr.r4.rs2;
        id_uop.fp_rs3      = instr.r4.rs3;
        id_uop.writes_fp   = 1'b1;
        id_uop.fp_rd       = instr.r4.rd;
      end
      OPC_SYSTEM: begin
        // funct3 of zero is ECALL, EBREAK and friends, none of which touch a CSR
        if (instr.csr.funct3 != 3'b000) begin
          id_uop.is_csr        = 1'b1;
          id_uop.rd            = instr.csr.rd;
          id_uop.fp_csr_access = csr_is_fp;
          // Only the register forms read rs1
          if (!instr.csr.funct3[2]) begin
            id_uop.rs1 = instr.csr.rs1;
          end
          // Set and clear with a zero mask leave the CSR untouched
          id_uop.writes_csr = !(instr.csr.funct3[1] && (instr.csr.rs1 == 5'd0));
        end
      end
      default: begin
      end
    endcase
  end

  // A stalled or empty decode stage sends a bubble to EX
  assign issue_uop = (stall || !instr_valid) ? UOP_INVALID : id_uop;

  // The source keeps a stalled word on the inputs until decode takes it
  a_hold_word_on_stall: assert property (
    @(posedge clk) instr_valid && stall |=> instr_valid && $stable(instr)
  ) else $error("Instruction word changed while stalled");

endmodule

// File: source/stage_slot.sv
module stage_slot import pipe_pkg::*; (
  input  logic        clk,
  input  logic        reset,
  input  uop_t        in_uop,
  input  logic        unit_done,
  output slot_state_t state,
  output uop_t        pass_uop
);

  uop_t uop_q;
  logic completed_q;
  logic holding;

  // ======================================
  // Occupancy
  // ======================================
  // An M op waits here until the unit reports done.
  // In the done cycle the slot lets go at once, so the stage behind it can move in
  assign holding = uop_q.valid && !completed_q && !unit_done;

  always_ff @(posedge clk) begin
    if (reset) begin
      uop_q       <= UOP_INVALID;
      completed_q <= 1'b0;
    end else if (!holding) begin
      uop_q       <= in_uop;
      // A fresh M op still owes its result, anything else is already complete
      completed_q <= !in_uop.is_muldiv;
    end
  end

  // ======================================
  // Outputs
  // ======================================
  always_comb begin
    state.uop       = uop_q;
    state.completed = completed_q;
    state.holding   = holding;
  end

  // Only finished work ever leaves a slot, so the multi-cycle mark is dropped
  // on the way out and later stages never wait for the unit again
  always_comb begin
    pass_uop           = uop_q;
    pass_uop.is_muldiv = 1'b0;
    if (holding) begin
      pass_uop = UOP_INVALID;
    end
  end

  // Nothing may be offered to a held slot, or the offered uop would be lost
  a_no_entry_while_holding: assert property (
    @(posedge clk) disable iff (reset)
    holding |-> !in_uop.valid
  ) else $error("Slot was offered a uop while holding");

endmodule

// File: source/hazard_detection_unit.sv
module hazard_detection_unit import pipe_pkg::*; #(
  parameter int NUM_SLOTS = NUM_SLOTS_DEFAULT
) (
  input  uop_t                        id_uop,
  input  logic                        instr_valid,
  input  slot_state_t [NUM_SLOTS-1:0] slots,
  output logic                        stall,
  output logic                        bubble
);

  uop_t ex_uop;
  logic int_rs1_match;
  logic int_rs2_match;
  logic int_load_use;
  logic fp_src_match;
  logic fp_load_use;
  logic multi_cycle;
  logic csr_write_in_flight;
  logic fp_writer_in_flight;
  logic csr_raw;
  logic fp_flags;

  // Slot 0 is the EX stage
  assign ex_uop = slots[0].uop;

  // ======================================
  // Load-use
  // ======================================
  // x0 is hardwired, so a load into it never produces a dependency
  assign int_rs1_match = (ex_uop.rd == id_uop.rs1);
  assign int_rs2_match = (ex_uop.rd == id_uop.rs2);
  assign int_load_use  = ex_uop.valid && ex_uop.is_load && (ex_uop.rd != 5'd0) &&
                         (int_rs1_match || int_rs2_match);

  // The FP file has no zero register, so f0 counts like any other
  assign fp_src_match = (ex_uop.fp_rd == id_uop.fp_rs1) ||
                        (ex_uop.fp_rd == id_uop.fp_rs2) ||
                        (ex_uop.fp_rd == id_uop.fp_rs3);
  assign fp_load_use  = ex_uop.valid && ex_uop.is_fp_load && id_uop.uses_fp_src &&
                        fp_src_match;

  // ======================================
  // Multi-cycle occupancy
  // ======================================
  // EX is busy, so decode waits, but nothing needs a bubble because EX does not advance
  assign multi_cycle = slots[0].holding;

  // ======================================
  // CSR ordering
  // ======================================
  // Every stage counts, since the CSR file is only written at the end of the pipe
  always_comb begin
    csr_write_in_flight = 1'b0;
    fp_writer_in_flight = 1'b0;
    for (int k = 0; k < NUM_SLOTS; k++) begin
      csr_write_in_flight |= slots[k].uop.valid && slots[k].uop.writes_csr;
      fp_writer_in_flight |= slots[k].uop.valid && slots[k].uop.writes_fp;
    end
  end

  // Any write is enough, address matching would miss aliased CSRs
  assign csr_raw = id_uop.is_csr && csr_write_in_flight;

  // FP writers fold their flags in late, which would race a flags access in decode
  assign fp_flags = id_uop.fp_csr_access && fp_writer_in_flight;

  // ======================================
  // Stall and bubble
  // ======================================
  always_comb begin
    stall  = instr_valid &&
             (int_load_use || fp_load_use || multi_cycle || csr_raw || fp_flags);
    bubble = instr_valid &&
             (int_load_use || fp_load_use || csr_raw || fp_flags);
  end

endmodule

// File: source/pipe_control_top.sv
module pipe_control_top import isa_pkg::*, pipe_pkg::*; #(
  parameter int NUM_SLOTS = NUM_SLOTS_DEFAULT
) (
  input  logic        clk,
  input  logic        reset,
  input  instr_word_u instr,
  input  logic        instr_valid,
  input  logic        unit_done,
  output logic        stall,
  output logic        bubble,
  output logic        retire_valid,
  output logic [4:0]  retire_rd,
  output logic        retire_fp
);

  uop_t                        id_uop;
  uop_t                        issue_uop;
  // Entry 0 feeds EX and entry k+1 is what slot k hands on
  uop_t        [NUM_SLOTS:0]   uop_chain;
  slot_state_t [NUM_SLOTS-1:0] slot_states;
  uop_t                        retire_uop;

  // The hold logic lives in slot 0 and retirement in the last slot, so they must differ
  if (NUM_SLOTS < 2) begin : g_bad_depth
    $error("pipe_control_top needs at least two stage slots");
  end

  instr_decoder instr_decoder_inst (
    .clk         (clk),
    .instr       (instr),
    .instr_valid (instr_valid),
    .stall       (stall),
    .id_uop      (id_uop),
    .issue_uop   (issue_uop)
  );

  // ======================================
  // Stage chain
  // ======================================
  assign uop_chain[0] = issue_uop;

  for (genvar k = 0; k < NUM_SLOTS; k++) begin : g_slot
    stage_slot stage_slot_inst (
      .clk       (clk),
      .reset     (reset),
      .in_uop    (uop_chain[k]),
      .unit_done (unit_done),
      .state     (slot_states[k]),
      .pass_uop  (uop_chain[k+1])
    );
  end

  hazard_detection_unit #(
    .NUM_SLOTS (NUM_SLOTS)
  ) hazard_detection_unit_inst (
    .id_uop      (id_uop),
    .instr_valid (instr_valid),
    .slots       (slot_states),
    .stall       (stall),
    .bubble      (bubble)
  );

  // ======================================
  // Retirement
  // ======================================
  // Whatever the last slot would hand on is the instruction that retires this cycle
  assign retire_uop   = uop_chain[NUM_SLOTS];
  assign retire_valid = retire_uop.valid;
  assign retire_fp    = retire_uop.valid && retire_uop.writes_fp;
  // Report the register in whichever file the result lands
  assign retire_rd    = retire_uop.writes_fp ? retire_uop.fp_rd : retire_uop.rd;

endmodule

// File: tests/tb_checker.sv
module tb_checker (
  input  logic       clk,
  input  logic       reset,
  input  logic       run_done,
  input  logic       stall,
  input  logic       bubble,
  input  logic       retire_valid,
  input  logic [4:0] retire_rd,
  input  logic       retire_fp,
  output logic       checks_done,
  output int         error_count,
  output int         tests_passed,
  output int         tests_failed
);

  // Expected values of the row currently on the DUT inputs
  string      cur_name       = "";
  logic       cur_active     = 1'b0;
  logic       cur_valid      = 1'b0;
  logic       cur_fp_writer  = 1'b0;
  logic [4:0] cur_rd         = '0;
  logic       cur_last       = 1'b0;
  logic       exp_stall      = 1'b0;
  logic       exp_bubble     = 1'b0;

  int    errors_seen    = 0;
  int    test_errors    = 0;
  int    passed_count   = 0;
  int    failed_count   = 0;
  int    retire_count   = 0;
  int    accept_count   = 0;
  logic  final_done     = 1'b0;
  // Expected retire_fp of every accepted instruction, oldest first
  logic  fp_in_flight[$];
  // Expected retire_rd of every accepted instruction, in the same order
  logic [4:0] rd_in_flight[$];

  assign checks_done  = final_done;
  assign error_count  = errors_seen;
  assign tests_passed = passed_count;
  assign tests_failed = failed_count;

  // Called by the stimulus side on the falling edge where it drives a row
  task automatic set_expected(input string name, input logic valid, input logic stall_exp,
                              input logic bubble_exp, input logic fp_writer,
                              input logic [4:0] rd_exp, input logic last);
    cur_name      = name;
    cur_valid     = valid;
    exp_stall     = stall_exp;
    exp_bubble    = bubble_exp;
    cur_fp_writer = fp_writer;
    cur_rd        = rd_exp;
    cur_last      = last;
    cur_active    = 1'b1;
  endtask

  task automatic report_mismatch(input string what, input logic [4:0] expected,
                                 input logic [4:0] actual);
    $display("Mismatch in test %s: %s expected %0d, actual %0d",
             cur_name, what, expected, actual);
    test_errors++;
    errors_seen++;
  endtask

  // ========================================
  // Retirement tracking
  // ========================================
  // Instructions leave the pipe in the order they were accepted
  task automatic check_retirement();
    logic       fp_expected;
    logic [4:0] rd_expected;
    if (retire_valid) begin
      retire_count++;
      if (fp_in_flight.size() == 0) begin
        $display("Error in test %s: an instruction retired with nothing in flight", cur_name);
        test_errors++;
        errors_seen++;
      end else begin
        fp_expected = fp_in_flight.pop_front();
        rd_expected = rd_in_flight.pop_front();
        if (retire_fp !== fp_expected) begin
          report_mismatch("retire_fp", fp_expected, retire_fp);
        end
        if (retire_rd !== rd_expected) begin
          report_mismatch("retire_rd", rd_expected, retire_rd);
        end
      end
    end
  endtask

  // ========================================
  // Sampling
  // ========================================
  // Inputs change on the falling edge, so one unit later everything has settled
  // and the next rising edge is still one unit away
  always @(negedge clk) begin
    #1;
    if (run_done && !final_done) begin
      if (fp_in_flight.size() != 0) begin
        $display("Error at end of run: %0d accepted instructions never retired",
                 fp_in_flight.size());
        errors_seen++;
      end
      if (retire_count != accept_count) begin
        $display("Error at end of run: %0d instructions retired but %0d were accepted",
                 retire_count, accept_count);
        errors_seen++;
      end
      final_done = 1'b1;
    end else if (!reset && cur_active && !run_done) begin
      if (stall !== exp_stall) begin
        report_mismatch("stall", exp_stall, stall);
      end
      if (bubble !== exp_bubble) begin
        report_mismatch("bubble", exp_bubble, bubble);
      end
      check_retirement();
      // An offered word with no expected stall is taken at the coming edge
      if (cur_valid && !exp_stall) begin
        fp_in_flight.push_back(cur_fp_writer);
        rd_in_flight.push_back(cur_rd);
        accept_count++;
      end
      if (cur_last) begin
        if (test_errors == 0) begin
          passed_count++;
          $display("Test %s: passed", cur_name);
        end else begin
          failed_count++;
          $display("Test %s: failed with %0d errors", cur_name, test_errors);
        end
        test_errors = 0;
      end
    end
  end

endmodule

// File: tests/tb_top.sv
module tb_top import isa_pkg::*; ();

  // One row of the stimulus table, applied for exactly one cycle
  typedef struct packed {
    logic [31:0] instr;
    logic        valid;
    logic        unit_done;
    logic        exp_stall;
    logic        exp_bubble;
    // Whether the accepted instruction should later retire with retire_fp set
    logic        fp_writer;
    // Destination register reported when the accepted instruction retires
    logic [4:0]  exp_rd;
  } row_t;

  localparam logic [11:0] CSR_MSTATUS  = 12'h300;
  localparam logic [11:0] CSR_MSCRATCH = 12'h340;

  logic        clk;
  logic        reset;
  logic [31:0] instr;
  logic        instr_valid;
  logic        unit_done;
  logic        stall;
  logic        bubble;
  logic        retire_valid;
  logic [4:0]  retire_rd;
  logic        retire_fp;
  logic        run_done;
  logic        checks_done;
  int          error_count;
  int          tests_passed;
  int          tests_failed;

  row_t   rows[$];
  string  row_names[$];
  integer seed        = 67;
  int     cycle_count = 0;
  int     cycle_limit = 0;

  pipe_control_top #(
    .NUM_SLOTS (3)
  ) pipe_control_top_inst (
    .clk          (clk),
    .reset        (reset),
    .instr        (instr),
    .instr_valid  (instr_valid),
    .unit_done    (unit_done),
    .stall        (stall),
    .bubble       (bubble),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_fp    (retire_fp)
  );

  tb_checker tb_checker_inst (
    .clk          (clk),
    .reset        (reset),
    .run_done     (run_done),
    .stall        (stall),
    .bubble       (bubble),
    .retire_valid (retire_valid),
    .retire_rd    (retire_rd),
    .retire_fp    (retire_fp),
    .checks_done  (checks_done),
    .error_count  (error_count),
    .tests_passed (tests_passed),
    .tests_failed (tests_failed)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // ========================================
  // Instruction encoding
  // ========================================
  function automatic logic [31:0] encode_r(input logic [6:0] funct7, input logic [4:0] rs2,
                                           input logic [4:0] rs1, input logic [2:0] funct3,
                                           input logic [4:0] rd, input logic [6:0] opcode);
    return {funct7, rs2, rs1, funct3, rd, opcode};
  endfunction

  // Loads and CSR accesses share the I-type layout
  function automatic logic [31:0] encode_i(input logic [11:0] imm, input logic [4:0] rs1,
                                           input logic [2:0] funct3, input logic [4:0] rd,
                                           input logic [6:0] opcode);
    return {imm, rs1, funct3, rd, opcode};
  endfunction

  // Single precision FMADD with round-to-nearest
  function automatic logic [31:0] encode_fmadd(input logic [4:0] rs3, input logic [4:0] rs2,
                                               input logic [4:0] rs1, input logic [4:0] rd);
    return {rs3, 2'b00, rs2, rs1, 3'b000, rd, OPC_FMADD};
  endfunction

  function automatic logic [4:0] random_reg();
    logic [31:0] r;
    r = $random(seed);
    return r[4:0];
  endfunction

  function automatic logic [4:0] random_nonzero_reg();
    logic [31:0] r;
    r = $random(seed);
    return (r[4:0] == 5'd0) ? 5'd1 : r[4:0];
  endfunction

  function automatic logic [11:0] random_imm();
    logic [31:0] r;
    r = $random(seed);
    return r[11:0];
  endfunction

  // ========================================
  // Stimulus table
  // ========================================
  task automatic add_row(input string name, input logic [31:0] word, input logic done,
                         input logic stall_exp, input logic bubble_exp, input logic fp_writer);
    row_t row;
    row.instr      = word;
    row.valid      = 1'b1;
    row.unit_done  = done;
    row.exp_stall  = stall_exp;
    row.exp_bubble = bubble_exp;
    row.fp_writer  = fp_writer;
    // Every format in the table writes a register named by the rd field
    row.exp_rd     = word[11:7];
    rows.push_back(row);
    row_names.push_back(name);
  endtask

  // Empty decode cycles, which also let the pipe drain
  task automatic add_idle(input string name, input int count);
    for (int i = 0; i < count; i++) begin
      rows.push_back('0);
      row_names.push_back(name);
    end
  endtask

  task automatic build_table();
    logic [31:0] word;
    add_idle("reset", 3);

    // A load into x5 makes its reader wait one cycle, a load into x0 never does
    word = encode_i(random_imm(), random_reg(), 3'b010, 5'd5, OPC_LOAD);
    add_row("int_load_use", word, 1'b0, 1'b0, 1'b0, 1'b0);
    word = encode_r(7'd0, random_reg(), 5'd5, 3'b000, random_reg(), OPC_OP);
    add_row("int_load_use", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("int_load_use", word, 1'b0, 1'b0, 1'b0, 1'b0);
    word = encode_i(random_imm(), random_reg(), 3'b010, 5'd0, OPC_LOAD);
    add_row("int_load_use", word, 1'b0, 1'b0, 1'b0, 1'b0);
    word = encode_r(7'd0, random_reg(), 5'd0, 3'b000, random_reg(), OPC_OP);
    add_row("int_load_use", word, 1'b0, 1'b0, 1'b0, 1'b0);
    add_idle("int_load_use", 3);

    // f0 is a real register and the match is only through the third source
    word = encode_i(random_imm(), random_reg(), 3'b010, 5'd0, OPC_LOAD_FP);
    add_row("fp_load_use", word, 1'b0, 1'b0, 1'b0, 1'b1);
    word = encode_fmadd(5'd0, random_nonzero_reg(), random_nonzero_reg(), random_reg());
    add_row("fp_load_use", word, 1'b0, 1'b1, 1'b1, 1'b1);
    add_row("fp_load_use", word, 1'b0, 1'b0, 1'b0, 1'b1);
    add_idle("fp_load_use", 3);

    // EX is busy until unit_done, so the ADD stalls without a bubble
    word = encode_r(FUNCT7_MULDIV, random_reg(), random_reg(), 3'b000, random_reg(), OPC_OP);
    add_row("multi_cycle", word, 1'b0, 1'b0, 1'b0, 1'b0);
    word = encode_r(7'd0, random_reg(), random_reg(), 3'b000, random_reg(), OPC_OP);
    add_row("multi_cycle", word, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row("multi_cycle", word, 1'b0, 1'b1, 1'b0, 1'b0);
    add_row("multi_cycle", word, 1'b1, 1'b0, 1'b0, 1'b0);
    add_idle("multi_cycle", 3);

    // The CSR read waits while the write sits in any of the three slots
    word = encode_i(CSR_MSCRATCH, random_reg(), 3'b001, random_reg(), OPC_SYSTEM);
    add_row("csr_raw", word, 1'b0, 1'b0, 1'b0, 1'b0);
    word = encode_i(CSR_MSCRATCH, 5'd0, 3'b010, random_reg(), OPC_SYSTEM);
    add_row("csr_raw", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("csr_raw", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("csr_raw", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("csr_raw", word, 1'b0, 1'b0, 1'b0, 1'b0);
    add_idle("csr_raw", 3);

    // Reading fflags behind an FP writer waits until the writer has left the pipe
    word = encode_r(7'd0, random_reg(), random_reg(), 3'b000, random_reg(), OPC_OP_FP);
    add_row("fp_flags_fflags", word, 1'b0, 1'b0, 1'b0, 1'b1);
    word = encode_i(CSR_FFLAGS, 5'd0, 3'b010, random_reg(), OPC_SYSTEM);
    add_row("fp_flags_fflags", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("fp_flags_fflags", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("fp_flags_fflags", word, 1'b0, 1'b1, 1'b1, 1'b0);
    add_row("fp_flags_fflags", word, 1'b0, 1'b0, 1'b0, 1'b0);
    add_idle("fp_flags_fflags", 3);

    // mstatus is not an FP CSR, so there is nothing to wait for
    word = encode_r(7'd0, random_reg(), random_reg(), 3'b000, random_reg(), OPC_OP_FP);
    add_row("fp_flags_mstatus", word, 1'b0, 1'b0, 1'b0, 1'b1);
    word = encode_i(CSR_MSTATUS, 5'd0, 3'b010, random_reg(), OPC_SYSTEM);
    add_row("fp_flags_mstatus", word, 1'b0, 1'b0, 1'b0, 1'b0);
    add_idle("fp_flags_mstatus", 4);
  endtask

  // ========================================
  // Run control
  // ========================================
  always @(posedge clk) begin
    if (!reset) begin
      cycle_count = cycle_count + 1;
      if (cycle_count >= cycle_limit) begin
        $display("Timeout: the run did not finish within %0d cycles", cycle_limit);
        $display("Verification failed");
        $finish;
      end
    end
  end

  initial begin
    logic last;
    reset       = 1'b1;
    instr       = '0;
    instr_valid = 1'b0;
    unit_done   = 1'b0;
    run_done    = 1'b0;
    build_table();
    cycle_limit = rows.size() + 20;
    repeat (10) @(posedge clk);
    @(negedge clk);
    reset = 1'b0;

    for (int i = 0; i < rows.size(); i++) begin
      @(negedge clk);
      instr       = rows[i].instr;
      instr_valid = rows[i].valid;
      unit_done   = rows[i].unit_done;
      // A test ends on its last row, which is where the checker prints its line
      if (i == rows.size() - 1) begin
        last = 1'b1;
      end else begin
        last = (row_names[i + 1] != row_names[i]);
      end
      tb_checker_inst.set_expected(row_names[i], rows[i].valid, rows[i].exp_stall,
                                   rows[i].exp_bubble, rows[i].fp_writer,
                                   rows[i].exp_rd, last);
    end

    @(negedge clk);
    instr_valid = 1'b0;
    unit_done   = 1'b0;
    run_done    = 1'b1;
    wait (checks_done);

    $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
             tests_passed, tests_failed, error_count);
    if (tests_failed != 0 || error_count != 0) begin
      $display("Verification failed");
    end else begin
      $display("Verification passed");
    end
    $finish;
  end

endmodule

// File: tb.f
source/isa_pkg.sv
source/pipe_pkg.sv
source/instr_decoder.sv
source/stage_slot.sv
source/hazard_detection_unit.sv
source/pipe_control_top.sv
tests/tb_checker.sv
tests/tb_top.sv

// File: run.sh
#!/usr/bin/env bash
# Build the simulation with Verilator and run it from the project root
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f tb.f --top-module tb_top \
  --Mdir obj_dir -o tb_sim || { echo "Build failed"; exit 1; }

sim_out="$(./obj_dir/tb_sim)"
echo "$sim_out"
grep -qx "Verification passed" <<< "$sim_out" && exit 0 || exit 1
